// ==== addr_decode.sv ====
`timescale 1ns/1ps
`include "mem_route_defs.svh"

module addr_decode
(
    input  logic                      CLK,
    input  logic                      RSTN,
    input  mem_route_pkg::mem_req_t   proc_req,
    input  logic                      cache_ready_ins,
    input  logic                      cache_ready_dat,
    input  logic                      phy_addr_valid,
    input  logic                      fetch_warm,
    output mem_route_pkg::mem_ctrl_t  cache_ctrl,
    output logic                      region_peri,
    output logic                      ext_fifo_wr_enb,
    output mem_route_pkg::data_t      ext_fifo_wr_data
);

    logic is_fifo;
    logic below_base;
    logic fifo_store;

    //////////////////////////////////////////////////
    // Region decode
    //////////////////////////////////////////////////
    assign is_fifo     = proc_req.addr == mem_route_pkg::addr_t'(`EXT_FIFO_ADDRESS);
    assign below_base  = proc_req.addr < mem_route_pkg::addr_t'(`PERIPHERAL_BASE_ADDR);
    // FIFO word sits above the base but is not peripheral space
    assign region_peri = !below_base && !is_fifo;

    assign cache_ctrl = (below_base && !is_fifo && cache_ready_ins && phy_addr_valid &&
                         fetch_warm) ? proc_req.ctrl : mem_route_pkg::ctrl_none;

    //////////////////////////////////////////////////
    // External FIFO store
    //////////////////////////////////////////////////
    assign fifo_store = is_fifo && proc_req.ctrl == mem_route_pkg::ctrl_write &&
                        cache_ready_ins && cache_ready_dat;

    always_ff @(posedge CLK)
    begin
        if (!RSTN)
        begin
            ext_fifo_wr_enb <= 1'b0;
        end
        else
        begin
            ext_fifo_wr_enb <= fifo_store;
        end
    end

    always_ff @(posedge CLK)
    begin
        if (fifo_store)
        begin
            ext_fifo_wr_data <= proc_req.wdata;
        end
    end

    // Peripheral requests never reach the data cache
    a_peri_not_cached: assert property (@(posedge CLK) disable iff (!RSTN)
        region_peri |-> cache_ctrl == mem_route_pkg::ctrl_none);

endmodule

// ==== compile.f ====
+incdir+.
mem_route_pkg.sv
addr_decode.sv
peri_access_seq.sv
proc_response.sv
mem_route_top.sv
mem_route_checker.sv
tb_mem_route.sv

// ==== mem_route_checker.sv ====
`timescale 1ns/1ps
`include "mem_route_defs.svh"

module mem_route_checker
(
    input  logic                       CLK,
    input  logic                       RSTN,
    input  logic                       test_done,
    input  logic [7:0]                 test_id,
    input  mem_route_pkg::mem_req_t    proc_req,
    input  logic                       cache_ready_ins,
    input  logic                       cache_ready_dat,
    input  logic                       exstage_stalled,
    input  logic                       phy_addr_valid,
    input  mem_route_pkg::data_t       cache_rdata,
    input  mem_route_pkg::mem_ctrl_t   cache_ctrl,
    input  logic                       peri_start,
    input  mem_route_pkg::peri_req_t   peri_req,
    input  logic                       ext_fifo_wr_enb,
    input  mem_route_pkg::data_t       ext_fifo_wr_data,
    input  logic                       fetch_ready,
    input  logic                       data_ready,
    input  logic                       data_from_peri_sel,
    input  mem_route_pkg::data_t       proc_rdata,
    output int                         err_total,
    output int                         tests_done
);

    logic [1:0]                warm_cnt;
    logic                      warm;
    logic                      qualify;
    logic                      busy_q;
    logic                      read_q;
    logic                      start_q;
    logic                      fifo_q;
    logic                      sel_q;
    logic                      crd_q;
    mem_route_pkg::data_t      fifo_data_q;
    mem_route_pkg::data_t      word_q;
    mem_route_pkg::peri_req_t  peri_q;
    mem_route_pkg::mem_ctrl_t  exp_ctrl;
    logic                      exp_fifo;
    logic                      exp_accept;
    mem_route_pkg::peri_req_t  exp_peri;
    mem_route_pkg::data_t      exp_word;
    int                        errs = 0;
    int                        done_cnt = 0;
    int                        err_mark = 0;

    assign err_total  = errs;
    assign tests_done = done_cnt;
    assign warm       = warm_cnt == 2'(`TLB_WARMUP);
    assign qualify    = cache_ready_ins && !exstage_stalled && !busy_q && phy_addr_valid;

    //////////////////////////////////////////////////
    // Reference model of the routing rules
    //////////////////////////////////////////////////
    function automatic void predict(
        input  mem_route_pkg::mem_req_t  req,
        input  logic                     warm_now,
        input  logic                     busy_now,
        output mem_route_pkg::mem_ctrl_t ctrl,
        output logic                     fifo_wr,
        output logic                     accept,
        output mem_route_pkg::peri_req_t preq,
        output mem_route_pkg::data_t     word
    );
        logic fifo_word;
        logic cacheable;
        fifo_word  = req.addr == {7'd0, `EXT_FIFO_ADDRESS};
        cacheable  = !fifo_word && req.addr < {7'd0, `PERIPHERAL_BASE_ADDR};
        ctrl       = (cacheable && cache_ready_ins && phy_addr_valid && warm_now) ?
                     req.ctrl : mem_route_pkg::ctrl_none;
        fifo_wr    = fifo_word && req.ctrl == mem_route_pkg::ctrl_write &&
                     cache_ready_ins && cache_ready_dat;
        accept     = !cacheable && !fifo_word && req.ctrl != mem_route_pkg::ctrl_none &&
                     !busy_now && cache_ready_ins && cache_ready_dat;
        preq.write = req.ctrl == mem_route_pkg::ctrl_write;
        preq.addr  = req.addr;
        preq.wdata = req.wdata[`PERI_DATA_W-1:0];
        preq.wstrb = req.byte_enb[`PERI_DATA_W/8-1:0];
        // Peripheral model answers with the address pattern
        word       = {32'd0, req.addr[31:0] ^ 32'h5a5a5a5a};
    endfunction

    task automatic report_mismatch(input string name, input logic [127:0] exp,
                                   input logic [127:0] got);
        $display("Error at %0t: %s expected %0h got %0h", $time, name, exp, got);
        errs++;
    endtask

    task automatic report_fault(input string msg);
        $display("Failure at %0t: %s", $time, msg);
        errs++;
    endtask

    always @(posedge CLK)
    begin
        predict(proc_req, warm, busy_q, exp_ctrl, exp_fifo, exp_accept, exp_peri, exp_word);
        if (!RSTN)
        begin
            warm_cnt <= '0;
            busy_q   <= 1'b0;
            start_q  <= 1'b0;
            fifo_q   <= 1'b0;
            sel_q    <= 1'b0;
            crd_q    <= 1'b0;
        end
        else
        begin
            if (cache_ctrl !== exp_ctrl)
                report_mismatch("cache_ctrl", 128'(exp_ctrl), 128'(cache_ctrl));
            if (ext_fifo_wr_enb !== fifo_q)
                report_mismatch("ext_fifo_wr_enb", 128'(fifo_q), 128'(ext_fifo_wr_enb));
            else if (fifo_q && ext_fifo_wr_data !== fifo_data_q)
                report_mismatch("ext_fifo_wr_data", 128'(fifo_data_q), 128'(ext_fifo_wr_data));
            if (peri_start !== start_q)
                report_mismatch("peri_start", 128'(start_q), 128'(peri_start));
            else if (start_q && peri_req !== peri_q)
                report_mismatch("peri_req", 128'(peri_q), 128'(peri_req));
            if (fetch_ready !== (qualify && warm))
                report_mismatch("fetch_ready", 128'(qualify && warm), 128'(fetch_ready));
            if (data_ready && !cache_ready_dat)
                report_fault("data_ready is high while cache_ready_dat is low");
            if (data_from_peri_sel && !busy_q)
                report_fault("data_from_peri_sel is high with no peripheral access open");
            if (data_from_peri_sel && !sel_q && !crd_q)
                report_fault("data_from_peri_sel rose right after a back-pressure cycle");
            if (data_from_peri_sel && data_ready && read_q && proc_rdata !== word_q)
                report_mismatch("proc_rdata", 128'(word_q), 128'(proc_rdata));
            if (!data_from_peri_sel && proc_rdata !== cache_rdata)
                report_mismatch("proc_rdata", 128'(cache_rdata), 128'(proc_rdata));

            // Advance the model
            if (qualify && !warm)
                warm_cnt <= warm_cnt + 2'd1;
            fifo_q  <= exp_fifo;
            start_q <= exp_accept;
            if (exp_fifo)
                fifo_data_q <= proc_req.wdata;
            if (exp_accept)
            begin
                busy_q <= 1'b1;
                peri_q <= exp_peri;
                word_q <= exp_word;
                read_q <= proc_req.ctrl == mem_route_pkg::ctrl_read;
            end
            else if (data_from_peri_sel && data_ready)
                busy_q <= 1'b0;
            sel_q <= data_from_peri_sel;
            crd_q <= cache_ready_dat;
        end
        if (test_done)
        begin
            $display("Test %0d finished: %s, %0d errors", test_id,
                     (errs == err_mark) ? "ok" : "failed", errs - err_mark);
            err_mark = errs;
            done_cnt++;
        end
    end

endmodule

// ==== mem_route_defs.svh ====
`ifndef MEM_ROUTE_DEFS_SVH
`define MEM_ROUTE_DEFS_SVH

//////////////////////////////////////////////////
// Bus widths
//////////////////////////////////////////////////
`define ADDR_W               39
`define DATA_W               64
`define PERI_DATA_W          32

//////////////////////////////////////////////////
// Address map
//////////////////////////////////////////////////
`define PERIPHERAL_BASE_ADDR 32'h10000000
`define EXT_FIFO_ADDRESS     32'he0001030

// Earliest completion count of a peripheral access
`define PERI_MIN_CYCLES      3
// Qualifying cycles before fetch is let through
`define TLB_WARMUP           3

`endif

// ==== mem_route_pkg.sv ====
`include "mem_route_defs.svh"

package mem_route_pkg;

    typedef logic [`ADDR_W-1:0]        addr_t;
    typedef logic [`DATA_W-1:0]        data_t;
    typedef logic [`PERI_DATA_W-1:0]   peri_data_t;
    typedef logic [`DATA_W/8-1:0]      byte_enb_t;
    typedef logic [`PERI_DATA_W/8-1:0] wstrb_t;

    // Data port control in the pipeline's coding
    typedef enum logic [1:0]
    {
        ctrl_none  = 2'd0,
        ctrl_read  = 2'd1,
        ctrl_write = 2'd2
    } mem_ctrl_t;

    typedef struct packed
    {
        mem_ctrl_t ctrl;
        addr_t     addr;
        data_t     wdata;
        byte_enb_t byte_enb;
    } mem_req_t;

    typedef struct packed
    {
        logic       write;
        addr_t      addr;
        peri_data_t wdata;
        wstrb_t     wstrb;
    } peri_req_t;

    typedef enum logic [2:0]
    {
        st_idle,
        st_issue,
        st_count,
        st_wait_done,
        st_respond
    } peri_state_t;

endpackage

// ==== mem_route_top.sv ====
`timescale 1ns/1ps

module mem_route_top
(
    input  logic                       CLK,
    input  logic                       RSTN,
    input  mem_route_pkg::mem_req_t    proc_req,
    input  logic                       cache_ready_ins,
    input  logic                       cache_ready_dat,
    input  logic                       exstage_stalled,
    input  logic                       phy_addr_valid,
    input  mem_route_pkg::data_t       cache_rdata,
    input  mem_route_pkg::peri_data_t  peri_rdata,
    input  logic                       peri_complete,
    output mem_route_pkg::mem_ctrl_t   cache_ctrl,
    output logic                       peri_start,
    output mem_route_pkg::peri_req_t   peri_req,
    output logic                       ext_fifo_wr_enb,
    output mem_route_pkg::data_t       ext_fifo_wr_data,
    output logic                       fetch_ready,
    output logic                       data_ready,
    output logic                       data_from_peri_sel,
    output mem_route_pkg::data_t       proc_rdata
);

    logic                 region_peri;
    logic                 fetch_warm;
    logic                 stop_ins;
    logic                 stop_dat;
    mem_route_pkg::data_t peri_rdata_q;

    addr_decode addr_decode_i
    (
        .CLK              (CLK),
        .RSTN             (RSTN),
        .proc_req         (proc_req),
        .cache_ready_ins  (cache_ready_ins),
        .cache_ready_dat  (cache_ready_dat),
        .phy_addr_valid   (phy_addr_valid),
        .fetch_warm       (fetch_warm),
        .cache_ctrl       (cache_ctrl),
        .region_peri      (region_peri),
        .ext_fifo_wr_enb  (ext_fifo_wr_enb),
        .ext_fifo_wr_data (ext_fifo_wr_data)
    );

    peri_access_seq peri_access_seq_i
    (
        .CLK                (CLK),
        .RSTN               (RSTN),
        .req                (proc_req),
        .region_peri        (region_peri),
        .cache_ready_ins    (cache_ready_ins),
        .cache_ready_dat    (cache_ready_dat),
        .peri_complete      (peri_complete),
        .peri_rdata         (peri_rdata),
        .peri_start         (peri_start),
        .peri_req           (peri_req),
        .stop_ins           (stop_ins),
        .stop_dat           (stop_dat),
        .data_from_peri_sel (data_from_peri_sel),
        .peri_rdata_q       (peri_rdata_q)
    );

    proc_response proc_response_i
    (
        .CLK                (CLK),
        .RSTN               (RSTN),
        .cache_ready_ins    (cache_ready_ins),
        .cache_ready_dat    (cache_ready_dat),
        .exstage_stalled    (exstage_stalled),
        .phy_addr_valid     (phy_addr_valid),
        .stop_ins           (stop_ins),
        .stop_dat           (stop_dat),
        .data_from_peri_sel (data_from_peri_sel),
        .cache_rdata        (cache_rdata),
        .peri_rdata_q       (peri_rdata_q),
        .fetch_warm         (fetch_warm),
        .fetch_ready        (fetch_ready),
        .data_ready         (data_ready),
        .proc_rdata         (proc_rdata)
    );

endmodule

// ==== peri_access_seq.sv ====
`timescale 1ns/1ps
`include "mem_route_defs.svh"

module peri_access_seq
(
    input  logic                       CLK,
    input  logic                       RSTN,
    input  mem_route_pkg::mem_req_t    req,
    input  logic                       region_peri,
    input  logic                       cache_ready_ins,
    input  logic                       cache_ready_dat,
    input  logic                       peri_complete,
    input  mem_route_pkg::peri_data_t  peri_rdata,
    output logic                       peri_start,
    output mem_route_pkg::peri_req_t   peri_req,
    output logic                       stop_ins,
    output logic                       stop_dat,
    output logic                       data_from_peri_sel,
    output mem_route_pkg::data_t       peri_rdata_q
);

    localparam int CNT_W = $clog2(`PERI_MIN_CYCLES + 1);

    mem_route_pkg::peri_state_t state;
    logic [CNT_W-1:0]           cnt;
    logic                       peri_done;
    logic                       busy;
    logic                       accept;
    logic                       cnt_at_min;

    assign busy       = state != mem_route_pkg::st_idle;
    assign accept     = region_peri && req.ctrl != mem_route_pkg::ctrl_none && !busy &&
                        cache_ready_ins && cache_ready_dat;
    assign cnt_at_min = cnt == CNT_W'(`PERI_MIN_CYCLES);

    //////////////////////////////////////////////////
    // Access sequencer
    //////////////////////////////////////////////////
    always_ff @(posedge CLK)
    begin
        if (!RSTN)
        begin
            state              <= mem_route_pkg::st_idle;
            cnt                <= '0;
            peri_start         <= 1'b0;
            stop_ins           <= 1'b0;
            stop_dat           <= 1'b0;
            peri_done          <= 1'b0;
            data_from_peri_sel <= 1'b0;
        end
        else
        begin
            peri_start <= 1'b0;
            // Completion pulse is kept even under back-pressure
            if (peri_complete && busy)
            begin
                peri_done <= 1'b1;
            end
            case (state)
                mem_route_pkg::st_idle:
                begin
                    if (accept)
                    begin
                        state      <= mem_route_pkg::st_issue;
                        cnt        <= CNT_W'(1);
                        peri_start <= 1'b1;
                        stop_ins   <= 1'b1;
                        peri_done  <= 1'b0;
                    end
                end
                mem_route_pkg::st_issue:
                begin
                    state <= mem_route_pkg::st_count;
                end
                mem_route_pkg::st_count:
                begin
                    if (cache_ready_dat)
                    begin
                        if (!cnt_at_min)
                        begin
                            cnt <= cnt + CNT_W'(1);
                        end
                        else if (peri_done)
                        begin
                            state              <= mem_route_pkg::st_respond;
                            data_from_peri_sel <= 1'b1;
                        end
                        else
                        begin
                            // Slow peripheral stalls the data port
                            state    <= mem_route_pkg::st_wait_done;
                            stop_dat <= 1'b1;
                        end
                    end
                end
                mem_route_pkg::st_wait_done:
                begin
                    if (cache_ready_dat && peri_done)
                    begin
                        state              <= mem_route_pkg::st_respond;
                        stop_dat           <= 1'b0;
                        data_from_peri_sel <= 1'b1;
                    end
                end
                mem_route_pkg::st_respond:
                begin
                    // Hold the select until the pipeline takes the word
                    if (cache_ready_dat && !stop_dat)
                    begin
                        state              <= mem_route_pkg::st_idle;
                        data_from_peri_sel <= 1'b0;
                        stop_ins           <= 1'b0;
                    end
                end
                default:
                begin
                    state <= mem_route_pkg::st_idle;
                end
            endcase
        end
    end

    //////////////////////////////////////////////////
    // Request and read data capture
    //////////////////////////////////////////////////
    always_ff @(posedge CLK)
    begin
        if (accept)
        begin
            peri_req.write <= req.ctrl == mem_route_pkg::ctrl_write;
            peri_req.addr  <= req.addr;
            peri_req.wdata <= req.wdata[`PERI_DATA_W-1:0];
            peri_req.wstrb <= req.byte_enb[`PERI_DATA_W/8-1:0];
        end
        if (peri_complete)
        begin
            peri_rdata_q <= {{(`DATA_W - `PERI_DATA_W){1'b0}}, peri_rdata};
        end
    end

    a_start_single: assert property (@(posedge CLK) disable iff (!RSTN)
        peri_start |=> !peri_start);

    // Every start comes out of an idle machine
    a_start_from_idle: assert property (@(posedge CLK) disable iff (!RSTN)
        peri_start |-> $past(state) == mem_route_pkg::st_idle);

endmodule

// ==== proc_response.sv ====
`timescale 1ns/1ps
`include "mem_route_defs.svh"

module proc_response
(
    input  logic                  CLK,
    input  logic                  RSTN,
    input  logic                  cache_ready_ins,
    input  logic                  cache_ready_dat,
    input  logic                  exstage_stalled,
    input  logic                  phy_addr_valid,
    input  logic                  stop_ins,
    input  logic                  stop_dat,
    input  logic                  data_from_peri_sel,
    input  mem_route_pkg::data_t  cache_rdata,
    input  mem_route_pkg::data_t  peri_rdata_q,
    output logic                  fetch_warm,
    output logic                  fetch_ready,
    output logic                  data_ready,
    output mem_route_pkg::data_t  proc_rdata
);

    localparam int WARM_W = $clog2(`TLB_WARMUP + 1);

    logic              qualify;
    logic [WARM_W-1:0] warm_cnt;

    // Fetch side may move this cycle
    assign qualify = cache_ready_ins && !exstage_stalled && !stop_ins && phy_addr_valid;

    //////////////////////////////////////////////////
    // Translation warm-up
    //////////////////////////////////////////////////
    always_ff @(posedge CLK)
    begin
        if (!RSTN)
        begin
            warm_cnt   <= '0;
            fetch_warm <= 1'b0;
        end
        else if (qualify && !fetch_warm)
        begin
            if (warm_cnt == WARM_W'(`TLB_WARMUP - 1))
            begin
                fetch_warm <= 1'b1;
            end
            warm_cnt <= warm_cnt + WARM_W'(1);
        end
    end

    //////////////////////////////////////////////////
    // Readiness and read data back to the pipeline
    //////////////////////////////////////////////////
    assign fetch_ready = qualify && fetch_warm;
    assign data_ready  = cache_ready_dat && !stop_dat;
    assign proc_rdata  = data_from_peri_sel ? peri_rdata_q : cache_rdata;

    // Fetch stays held through the whole peripheral access and its response
    a_fetch_held: assert property (@(posedge CLK) disable iff (!RSTN)
        (stop_ins || data_from_peri_sel) |-> !fetch_ready);

endmodule

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build and run the memory routing testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -sv -f compile.f --top-module tb_mem_route
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

sim_out=$(./obj_dir/Vtb_mem_route)
sim_status=$?
echo "$sim_out"
if [ $sim_status -ne 0 ]; then
    echo "Simulation exited with status $sim_status"
    exit 1
fi

if echo "$sim_out" | grep -qx "STATUS: PASS"; then
    exit 0
fi
echo "Pass message not found in simulation output"
exit 1

// ==== tb_mem_route.sv ====
`timescale 1ns/1ps
`include "mem_route_defs.svh"

module tb_mem_route;

    localparam int NUM_TESTS      = 6;
    localparam int MAX_PERI_DELAY = 7;
    localparam int TIMEOUT_CYCLES = NUM_TESTS * 40 + MAX_PERI_DELAY;

    logic                       CLK;
    logic                       RSTN;
    mem_route_pkg::mem_req_t    proc_req;
    logic                       cache_ready_ins;
    logic                       cache_ready_dat;
    logic                       exstage_stalled;
    logic                       phy_addr_valid;
    mem_route_pkg::data_t       cache_rdata;
    mem_route_pkg::peri_data_t  peri_rdata;
    logic                       peri_complete;
    mem_route_pkg::mem_ctrl_t   cache_ctrl;
    logic                       peri_start;
    mem_route_pkg::peri_req_t   peri_req;
    logic                       ext_fifo_wr_enb;
    mem_route_pkg::data_t       ext_fifo_wr_data;
    logic                       fetch_ready;
    logic                       data_ready;
    logic                       data_from_peri_sel;
    mem_route_pkg::data_t       proc_rdata;
    logic                       test_done;
    logic [7:0]                 test_id;
    int                         err_total;
    int                         tests_done;
    logic [31:0]                lfsr;
    logic [2:0]                 peri_delay;

    mem_route_top mem_route_top_i (.*);

    mem_route_checker checker_i (.*);

    initial
    begin
        CLK = 1'b0;
        forever #5 CLK = ~CLK;
    end

    // Fibonacci LFSR with taps 32 22 2 1
    function automatic logic [63:0] rand_bits(input int n);
        logic [63:0] v;
        logic        fb;
        v = '0;
        for (int i = 0; i < n; i++)
        begin
            fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
            lfsr = {lfsr[30:0], fb};
            v    = {v[62:0], fb};
        end
        return v;
    endfunction

    task automatic set_idle_req();
        proc_req.ctrl     = mem_route_pkg::ctrl_none;
        proc_req.addr     = '0;
        proc_req.wdata    = '0;
        proc_req.byte_enb = '0;
    endtask

    task automatic finish_test(input logic [7:0] id);
        test_id   = id;
        test_done = 1'b1;
        @(negedge CLK);
        test_done = 1'b0;
    endtask

    // One peripheral access with optional back-pressure right after the accept
    task automatic peri_access(input mem_route_pkg::mem_ctrl_t ctrl,
                               input mem_route_pkg::addr_t addr, input int stall);
        logic [63:0] tmp;
        tmp = rand_bits(64);
        proc_req.wdata = tmp;
        tmp = rand_bits(8);
        proc_req.byte_enb = tmp[7:0];
        tmp = rand_bits(3);
        peri_delay = tmp[2:0];
        proc_req.ctrl = ctrl;
        proc_req.addr = addr;
        @(negedge CLK);
        set_idle_req();
        if (stall > 0)
        begin
            // Competing request held through the stall and one ready cycle
            cache_ready_dat = 1'b0;
            proc_req.ctrl   = mem_route_pkg::ctrl_write;
            proc_req.addr   = addr;
            repeat (stall) @(negedge CLK);
            cache_ready_dat = 1'b1;
            @(negedge CLK);
            set_idle_req();
        end
        while (!(data_from_peri_sel && data_ready))
            @(negedge CLK);
        @(negedge CLK);
    endtask

    //////////////////////////////////////////////////
    // Peripheral model
    //////////////////////////////////////////////////
    initial
    begin : peri_model
        mem_route_pkg::peri_req_t seen;
        peri_complete = 1'b0;
        peri_rdata    = '0;
        forever
        begin
            @(negedge CLK);
            if (peri_start)
            begin
                seen = peri_req;
                repeat (peri_delay) @(negedge CLK);
                peri_complete = 1'b1;
                peri_rdata    = seen.write ? '0 : seen.addr[31:0] ^ 32'h5a5a5a5a;
                @(negedge CLK);
                peri_complete = 1'b0;
            end
        end
    end

    //////////////////////////////////////////////////
    // Stimulus
    //////////////////////////////////////////////////
    initial
    begin : stimulus
        logic [63:0] tmp;
        lfsr            = 32'd98459;
        RSTN            = 1'b0;
        test_done       = 1'b0;
        test_id         = 8'd0;
        peri_delay      = 3'd0;
        cache_ready_ins = 1'b1;
        cache_ready_dat = 1'b1;
        exstage_stalled = 1'b0;
        phy_addr_valid  = 1'b0;
        cache_rdata     = '0;
        set_idle_req();
        repeat (2) @(negedge CLK);
        RSTN = 1'b1;

        // Reset state with translation not yet valid
        proc_req.ctrl = mem_route_pkg::ctrl_read;
        proc_req.addr = 39'h0000001000;
        repeat (3) @(negedge CLK);
        set_idle_req();
        finish_test(8'd1);

        // Warm-up followed by random cacheable traffic
        phy_addr_valid = 1'b1;
        for (int i = 0; i < 20; i++)
        begin
            tmp = rand_bits(30);
            proc_req.ctrl   = tmp[29] ? mem_route_pkg::ctrl_write : mem_route_pkg::ctrl_read;
            proc_req.addr   = {11'd0, tmp[27:0]};
            exstage_stalled = (i < 6) ? tmp[28] : 1'b0;
            tmp = rand_bits(64);
            proc_req.wdata = tmp;
            tmp = rand_bits(64);
            cache_rdata = tmp;
            tmp = rand_bits(8);
            proc_req.byte_enb = tmp[7:0];
            @(negedge CLK);
        end
        set_idle_req();
        finish_test(8'd2);

        // FIFO store and then a FIFO read that must not strobe
        tmp = rand_bits(64);
        proc_req.ctrl     = mem_route_pkg::ctrl_write;
        proc_req.addr     = {7'd0, `EXT_FIFO_ADDRESS};
        proc_req.wdata    = tmp;
        proc_req.byte_enb = 8'hff;
        @(negedge CLK);
        proc_req.ctrl = mem_route_pkg::ctrl_read;
        @(negedge CLK);
        set_idle_req();
        repeat (2) @(negedge CLK);
        finish_test(8'd3);

        tmp = rand_bits(28);
        peri_access(mem_route_pkg::ctrl_write, {7'd0, 4'h4, tmp[27:0]}, 0);
        finish_test(8'd4);

        for (int i = 0; i < 4; i++)
        begin
            tmp = rand_bits(29);
            peri_access(mem_route_pkg::ctrl_read, {tmp[28], 6'd0, 4'h2, tmp[27:0]}, 0);
        end
        finish_test(8'd5);

        tmp = rand_bits(28);
        peri_access(mem_route_pkg::ctrl_read, {7'd0, 4'h3, tmp[27:0]}, 6);
        finish_test(8'd6);

        repeat (2) @(negedge CLK);
        $display("Tests run: %0d of %0d, errors: %0d", tests_done, NUM_TESTS, err_total);
        if (err_total == 0 && tests_done == NUM_TESTS)
            $display("STATUS: PASS");
        else
            $display("STATUS: FAIL");
        $finish;
    end

    initial
    begin : watchdog
        repeat (TIMEOUT_CYCLES) @(posedge CLK);
        $display("Timeout: the tests did not finish within %0d clock cycles", TIMEOUT_CYCLES);
        $display("STATUS: FAIL");
        $finish;
    end

endmodule
